// File: design/loader_pkg.sv
// Loader stream definitions for cartridge download indexing and header decode
`default_nettype none

package loader_pkg;

	// ====================
	// Download stream
	// ====================

	// Cartridge downloads carry zero in the low six index bits
	localparam logic [5:0] DL_INDEX_CART = 6'd0;

	// Copier header placed ahead of the ROM image
	localparam logic [24:0] HEADER_SKIP = 25'h200;

	// Stream byte address of the ROM size word, per layout
	// RAM size follows two bytes later
	localparam logic [24:0] LOROM_SIZE_OFS   = 25'h007FD6 + HEADER_SKIP;
	localparam logic [24:0] HIROM_SIZE_OFS   = 25'h00FFD6 + HEADER_SKIP;
	localparam logic [24:0] EXHIROM_SIZE_OFS = 25'h40FFD6 + HEADER_SKIP;

	// ====================
	// Header decode
	// ====================

	// Menu selection of the cartridge layout
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_t;

	// 24-bit address mask into cartridge space
	typedef logic [23:0] mem_mask_t;

	// Size nibble counts in kilobytes
	localparam mem_mask_t MASK_KB_SHIFT = 24'd1024;

endpackage

`default_nettype wire

// File: design/backup_pkg.sv
// Backup RAM definitions for sector geometry, clear value and transfer FSM states
`default_nettype none

package backup_pkg;

	// ====================
	// Sector geometry
	// ====================

	// One SD sector is 512 bytes, moved as 16-bit words
	localparam int SECTOR_WORDS     = 256;
	localparam int SECTOR_ADDR_BITS = $clog2(SECTOR_WORDS);

	// Erased battery RAM reads as all ones
	localparam logic [7:0] FILL_BYTE = 8'hFF;

	// ====================
	// Transfer FSM
	// ====================

	typedef enum logic [1:0] {
		BK_IDLE     = 2'd0,
		BK_TRANSFER = 2'd1,
		BK_WAIT_ACK = 2'd2
	} bk_state_t;

endpackage

`default_nettype wire

// File: design/cart_header_parser.sv
// Cartridge header parser that classifies the download and extracts ROM/RAM geometry and region
`timescale 1ns/1ps
`default_nettype none

module cart_header_parser (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      download,
	input  logic [7:0]                index,
	input  logic [24:0]               addr,
	input  logic [15:0]               dout,
	input  logic                      wr,
	input  loader_pkg::header_mode_t  header_mode,
	input  logic [1:0]                region_sel,
	output logic                      cart_download,
	output logic                      cart_start,
	output logic                      cart_end,
	output logic [7:0]                rom_type,
	output loader_pkg::mem_mask_t     rom_mask,
	output loader_pkg::mem_mask_t     ram_mask,
	output logic                      pal
);

	import loader_pkg::*;

	logic        old_download;
	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic [24:0] size_ofs;
	logic        layout_mode;

	// ====================
	// Download edges
	// ====================

	assign cart_download = download && (index[5:0] == DL_INDEX_CART);
	assign cart_start    = cart_download & ~old_download;
	assign cart_end      = old_download & ~cart_download;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
		end else begin
			old_download <= cart_download;
		end
	end

	// Where the size word sits for the chosen layout
	always_comb begin
		layout_mode = 1'b1;
		case (header_mode)
			HDR_LOROM:   size_ofs = LOROM_SIZE_OFS;
			HDR_HIROM:   size_ofs = HIROM_SIZE_OFS;
			HDR_EXHIROM: size_ofs = EXHIROM_SIZE_OFS;
			default: begin
				size_ofs    = LOROM_SIZE_OFS;
				layout_mode = 1'b0;
			end
		endcase
	end

	// ====================
	// Header capture
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size   <= 4'hC;
			ram_size   <= 4'h0;
			rom_type   <= 8'h00;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else if (cart_download) begin
			if (wr) begin
				if (addr == 25'd0) begin
					rom_size <= 4'hC;
					ram_size <= 4'h0;
					// Loader prepends size byte and type byte in auto mode
					if (header_mode == HDR_AUTO && dout[7:0] != 8'h00) begin
						{ram_size, rom_size} <= dout[7:0];
					end
					case (header_mode)
						HDR_NONE, HDR_LOROM: rom_type <= 8'd0;
						HDR_HIROM:           rom_type <= 8'd1;
						HDR_EXHIROM:         rom_type <= 8'd2;
						default:             rom_type <= dout[15:8];
					endcase
				end

				if (addr == 25'd2) begin
					rom_region <= dout[8];
				end

				// ROM size is the odd byte, RAM size the next even byte
				if (layout_mode && addr == size_ofs) begin
					rom_size <= dout[11:8];
				end
				if (layout_mode && addr == size_ofs + 25'd2) begin
					ram_size <= dout[3:0];
				end
			end
		end else begin
			pal <= (region_sel == 2'b00) ? rom_region : region_sel[1];
		end
	end

	// Sizes are powers of two in kilobytes
	assign rom_mask = (MASK_KB_SHIFT << rom_size) - 24'd1;
	assign ram_mask = (ram_size != 4'h0) ? (MASK_KB_SHIFT << ram_size) - 24'd1 : 24'd0;

endmodule

`default_nettype wire

// File: design/backup_ram.sv
// Dual-port backup RAM with byte core port, word SD port and fill on cartridge load
`timescale 1ns/1ps
`default_nettype none

module backup_ram #(
	parameter int BSRAM_BITS = 17
) (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    cart_start,
	input  logic [BSRAM_BITS-1:0]                   core_addr,
	input  logic [7:0]                              core_d,
	input  logic                                    core_we,
	output logic [7:0]                              core_q,
	input  logic [BSRAM_BITS-2-backup_pkg::SECTOR_ADDR_BITS:0] sd_lba,
	input  logic [backup_pkg::SECTOR_ADDR_BITS-1:0] sd_buff_addr,
	input  logic [15:0]                             sd_buff_dout,
	input  logic                                    sd_buff_wr,
	input  logic                                    sd_ack,
	output logic [15:0]                             sd_buff_din,
	output logic                                    clearing
);

	import backup_pkg::*;

	localparam int WORD_BITS = BSRAM_BITS - 1;

	// Byte 0 of each word is the even address
	logic [1:0][7:0]       mem [2**WORD_BITS];

	logic [BSRAM_BITS-1:0] fill_addr;
	logic [BSRAM_BITS-1:0] a_addr;
	logic [7:0]            a_data;
	logic                  a_we;
	logic [WORD_BITS-1:0]  b_addr;
	logic                  b_we;

	// Fill counter owns port A while clearing
	assign a_addr = clearing ? fill_addr : core_addr;
	assign a_data = clearing ? FILL_BYTE : core_d;
	assign a_we   = clearing | core_we;

	assign b_addr = {sd_lba, sd_buff_addr};
	assign b_we   = sd_buff_wr & sd_ack;

	// ====================
	// Memory array
	// ====================

	always_ff @(posedge clk_sys) begin
		if (a_we) begin
			mem[a_addr[BSRAM_BITS-1:1]][a_addr[0]] <= a_data;
		end
		if (b_we) begin
			mem[b_addr] <= sd_buff_dout;
		end
		core_q      <= mem[a_addr[BSRAM_BITS-1:1]][a_addr[0]];
		sd_buff_din <= mem[b_addr];
	end

	// ====================
	// Clear sequence
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			if (cart_start) begin
				clearing <= 1'b1;
			end
			// Last byte written, release the core port
			if (&fill_addr) begin
				clearing <= 1'b0;
			end
			if (clearing) begin
				fill_addr <= fill_addr + 1'b1;
			end else begin
				fill_addr <= '0;
			end
		end
	end

	// Host must not load a save while the cartridge fill is running
	a_no_sd_during_clear: assert property (
		@(posedge clk_sys) disable iff (reset)
		clearing |-> !(sd_buff_wr && sd_ack)
	);

endmodule

`default_nettype wire

// File: design/backup_sequencer.sv
// Backup transfer FSM that moves sectors between the buffer and the save image
`timescale 1ns/1ps
`default_nettype none

module backup_sequencer #(
	parameter int BSRAM_BITS = 17
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cart_download,
	input  logic                  cart_start,
	input  logic                  cart_end,
	input  loader_pkg::mem_mask_t ram_mask,
	input  logic                  img_mounted,
	input  logic                  img_readonly,
	input  logic                  img_nonempty,
	input  logic                  bk_load,
	input  logic                  bk_save,
	input  logic                  autosave,
	input  logic                  osd_status,
	input  logic                  core_we,
	input  logic                  sd_ack,
	output logic [31:0]           sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	output logic                  loading,
	output logic                  saving,
	output logic                  bk_ena,
	output logic                  pending
);

	import backup_pkg::*;

	// Sectors that fit in the buffer
	localparam int          LBA_BITS = BSRAM_BITS - 1 - SECTOR_ADDR_BITS;
	localparam logic [14:0] BUF_LAST = 15'((1 << LBA_BITS) - 1);

	bk_state_t   state;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        save_req;
	logic        load_edge;
	logic        save_edge;
	logic        auto_load;
	logic        start_load;
	logic [14:0] last_lba;

	// Menu open with unsaved writes counts as a save request
	assign save_req   = bk_save | (pending & osd_status & autosave);
	assign load_edge  = bk_load & bk_ena & ~old_load;
	assign save_edge  = save_req & bk_ena & ~old_save;
	assign auto_load  = cart_end & img_nonempty & bk_ena;
	assign start_load = load_edge | auto_load;

	// RAM larger than the buffer would wrap, stop at the buffer end
	assign last_lba = (ram_mask[23:9] > BUF_LAST) ? BUF_LAST : ram_mask[23:9];

	// ====================
	// Enable and pending
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena <= 1'b0;
		end else begin
			if (cart_start) begin
				bk_ena <= 1'b0;
			end
			// Save image is mounted while the ROM is still downloading
			if (cart_download && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (bk_ena && !osd_status && core_we) begin
			pending <= 1'b1;
		end else if (state != BK_IDLE || !bk_ena) begin
			pending <= 1'b0;
		end
	end

	// ====================
	// Sector FSM
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= BK_IDLE;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
			sd_lba   <= 32'd0;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			loading  <= 1'b0;
			saving   <= 1'b0;
		end else begin
			old_load <= bk_load & bk_ena;
			old_save <= save_req & bk_ena;
			old_ack  <= sd_ack;

			case (state)
				BK_IDLE: begin
					if (start_load | save_edge) begin
						sd_lba  <= 32'd0;
						sd_rd   <= start_load;
						sd_wr   <= ~start_load;
						loading <= start_load;
						saving  <= ~start_load;
						state   <= BK_WAIT_ACK;
					end
				end
				BK_WAIT_ACK: begin
					// Host took the request
					if (sd_ack & ~old_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_TRANSFER;
					end
				end
				BK_TRANSFER: begin
					if (old_ack & ~sd_ack) begin
						if (sd_lba >= {17'd0, last_lba}) begin
							loading <= 1'b0;
							saving  <= 1'b0;
							state   <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= loading;
							sd_wr  <= saving;
							state  <= BK_WAIT_ACK;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	a_rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr)
	);

	// Sector index stays inside the image across the whole transfer
	a_lba_in_range: assert property (
		@(posedge clk_sys) disable iff (reset)
		(state != BK_IDLE) |-> (sd_lba <= {17'd0, last_lba})
	);

endmodule

`default_nettype wire

// File: design/cart_backup_top.sv
// Cartridge backup top level joining header parser, backup RAM and transfer FSM
`timescale 1ns/1ps
`default_nettype none

module cart_backup_top #(
	parameter int BSRAM_BITS = 17
) (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    download,
	input  logic [7:0]                              index,
	input  logic [24:0]                             addr,
	input  logic [15:0]                             dout,
	input  logic                                    wr,
	input  loader_pkg::header_mode_t                header_mode,
	input  logic [1:0]                              region_sel,
	input  logic [BSRAM_BITS-1:0]                   core_addr,
	input  logic [7:0]                              core_d,
	input  logic                                    core_we,
	output logic [7:0]                              core_q,
	input  logic                                    img_mounted,
	input  logic                                    img_readonly,
	input  logic                                    img_nonempty,
	input  logic                                    bk_load,
	input  logic                                    bk_save,
	input  logic                                    autosave,
	input  logic                                    osd_status,
	input  logic                                    sd_ack,
	input  logic [backup_pkg::SECTOR_ADDR_BITS-1:0] sd_buff_addr,
	input  logic [15:0]                             sd_buff_dout,
	input  logic                                    sd_buff_wr,
	output logic [15:0]                             sd_buff_din,
	output logic [31:0]                             sd_lba,
	output logic                                    sd_rd,
	output logic                                    sd_wr,
	output logic                                    cart_download,
	output logic [7:0]                              rom_type,
	output loader_pkg::mem_mask_t                   rom_mask,
	output loader_pkg::mem_mask_t                   ram_mask,
	output logic                                    pal,
	output logic                                    saving,
	output logic                                    bk_ena,
	output logic                                    pending,
	output logic                                    busy,
	output logic                                    led
);

	import backup_pkg::*;

	localparam int LBA_BITS = BSRAM_BITS - 1 - SECTOR_ADDR_BITS;

	logic cart_start;
	logic cart_end;
	logic clearing;
	logic loading;

	cart_header_parser u_parser (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.download      (download),
		.index         (index),
		.addr          (addr),
		.dout          (dout),
		.wr            (wr),
		.header_mode   (header_mode),
		.region_sel    (region_sel),
		.cart_download (cart_download),
		.cart_start    (cart_start),
		.cart_end      (cart_end),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	backup_ram #(
		.BSRAM_BITS (BSRAM_BITS)
	) u_ram (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_start   (cart_start),
		.core_addr    (core_addr),
		.core_d       (core_d),
		.core_we      (core_we),
		.core_q       (core_q),
		.sd_lba       (sd_lba[LBA_BITS-1:0]),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_ack       (sd_ack),
		.sd_buff_din  (sd_buff_din),
		.clearing     (clearing)
	);

	backup_sequencer #(
		.BSRAM_BITS (BSRAM_BITS)
	) u_seq (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.cart_start    (cart_start),
		.cart_end      (cart_end),
		.ram_mask      (ram_mask),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_nonempty  (img_nonempty),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.autosave      (autosave),
		.osd_status    (osd_status),
		.core_we       (core_we),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.loading       (loading),
		.saving        (saving),
		.bk_ena        (bk_ena),
		.pending       (pending)
	);

	// Core is held off while RAM is filled or reloaded
	assign busy = clearing | loading;
	assign led  = cart_download | pending;

endmodule

`default_nettype wire

// File: tests/cart_backup_checker.sv
// Testbench checker that models header decode and backup RAM contents and compares the DUT
`timescale 1ns/1ps
`default_nettype none

module cart_backup_checker #(
	parameter int BSRAM_BITS = 12
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      download,
	input  logic [7:0]                index,
	input  logic [24:0]               addr,
	input  logic [15:0]               dout,
	input  logic                      wr,
	input  loader_pkg::header_mode_t  header_mode,
	input  logic [1:0]                region_sel,
	input  logic [BSRAM_BITS-1:0]     core_addr,
	input  logic [7:0]                core_d,
	input  logic                      core_we,
	input  logic                      core_rd,
	input  logic [7:0]                core_q,
	input  logic [31:0]               sd_lba,
	input  logic [7:0]                sd_buff_addr,
	input  logic [15:0]               sd_buff_dout,
	input  logic                      sd_buff_wr,
	input  logic                      sd_ack,
	input  logic [15:0]               sd_buff_din,
	input  logic                      save_chk,
	input  logic                      chk_hdr,
	input  logic [7:0]                rom_type,
	input  loader_pkg::mem_mask_t     rom_mask,
	input  loader_pkg::mem_mask_t     ram_mask,
	input  logic                      pal,
	input  logic                      cart_download,
	output int                        errors
);

	import loader_pkg::*;

	localparam int LBA_BITS = BSRAM_BITS - 9;

	logic [7:0]            mem [2**BSRAM_BITS];
	logic                  cdl;
	logic                  cdl_q;
	logic [3:0]            m_rom;
	logic [3:0]            m_ram;
	logic [7:0]            m_type;
	logic                  m_region;
	logic                  m_pal;
	logic                  rd_q;
	logic [BSRAM_BITS-1:0] rd_addr;
	logic                  sv_q;
	logic [BSRAM_BITS-2:0] sv_word;

	assign cdl = download && (index[5:0] == 6'd0);

	// Size word position per layout
	// The odd fallback never matches a word address
	function automatic logic [24:0] layout_ofs(input header_mode_t m);
		case (m)
			HDR_LOROM:   return 25'h00081D6;
			HDR_HIROM:   return 25'h00101D6;
			HDR_EXHIROM: return 25'h04101D6;
			default:     return 25'h1FFFFFF;
		endcase
	endfunction

	function automatic mem_mask_t size_mask(input logic [3:0] n, input logic zero_off);
		if (zero_off && n == 4'd0) begin
			return 24'd0;
		end
		return (24'd1024 << n) - 24'd1;
	endfunction

	// ====================
	// Compare and model
	// ====================

	always @(posedge clk_sys) begin
		if (reset) begin
			errors   = 0;
			cdl_q    <= 1'b0;
			m_rom    <= 4'hC;
			m_ram    <= 4'h0;
			m_type   <= 8'h00;
			m_region <= 1'b0;
			m_pal    <= 1'b0;
			rd_q     <= 1'b0;
			sv_q     <= 1'b0;
		end else begin
			if (cart_download !== cdl) begin
				$display("Error at %0t: cart_download is %b, expected %b",
					$time, cart_download, cdl);
				errors = errors + 1;
			end
			if (rd_q && core_q !== mem[rd_addr]) begin
				$display("Error at %0t: core read %h gave %h, expected %h",
					$time, rd_addr, core_q, mem[rd_addr]);
				errors = errors + 1;
			end
			if (sv_q && sd_buff_din !== {mem[{sv_word, 1'b1}], mem[{sv_word, 1'b0}]}) begin
				$display("Error at %0t: save word %h gave %h, expected %h", $time, sv_word,
					sd_buff_din, {mem[{sv_word, 1'b1}], mem[{sv_word, 1'b0}]});
				errors = errors + 1;
			end
			if (chk_hdr) begin
				if (rom_type !== m_type || rom_mask !== size_mask(m_rom, 1'b0) ||
					ram_mask !== size_mask(m_ram, 1'b1) || pal !== m_pal) begin
					$display("Error at %0t: header gave %h %h %h %b, expected %h %h %h %b",
						$time, rom_type, rom_mask, ram_mask, pal, m_type,
						size_mask(m_rom, 1'b0), size_mask(m_ram, 1'b1), m_pal);
					errors = errors + 1;
				end
			end

			rd_q    <= core_rd;
			rd_addr <= core_addr;
			sv_q    <= save_chk;
			sv_word <= {sd_lba[LBA_BITS-1:0], sd_buff_addr};
			cdl_q   <= cdl;

			// New cartridge erases the save RAM
			if (cdl && !cdl_q) begin
				for (int i = 0; i < 2**BSRAM_BITS; i++) begin
					mem[i] = 8'hFF;
				end
			end
			if (core_we) begin
				mem[core_addr] = core_d;
			end
			if (sd_buff_wr && sd_ack) begin
				mem[{sd_lba[LBA_BITS-1:0], sd_buff_addr, 1'b0}] = sd_buff_dout[7:0];
				mem[{sd_lba[LBA_BITS-1:0], sd_buff_addr, 1'b1}] = sd_buff_dout[15:8];
			end

			if (cdl) begin
				if (wr) begin
					if (addr == 25'd0) begin
						m_rom <= 4'hC;
						m_ram <= 4'h0;
						if (header_mode == HDR_AUTO && dout[7:0] != 8'h00) begin
							m_ram <= dout[7:4];
							m_rom <= dout[3:0];
						end
						case (header_mode)
							HDR_NONE, HDR_LOROM: m_type <= 8'd0;
							HDR_HIROM:           m_type <= 8'd1;
							HDR_EXHIROM:         m_type <= 8'd2;
							default:             m_type <= dout[15:8];
						endcase
					end
					if (addr == 25'd2) begin
						m_region <= dout[8];
					end
					if (addr == layout_ofs(header_mode)) begin
						m_rom <= dout[11:8];
					end
					if (addr == layout_ofs(header_mode) + 25'd2) begin
						m_ram <= dout[3:0];
					end
				end
			end else begin
				m_pal <= (region_sel == 2'b00) ? m_region : region_sel[1];
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/cart_backup_tb.sv
// Testbench for the cartridge backup path with SD host model and core bus stimulus
`timescale 1ns/1ps
`default_nettype none

module cart_backup_tb;

	import loader_pkg::*;

	localparam int BSRAM_BITS = 12;
	localparam int SECTORS    = 8;

	logic                  clk_sys;
	logic                  reset;
	logic                  download;
	logic [7:0]            index;
	logic [24:0]           addr;
	logic [15:0]           dout;
	logic                  wr;
	header_mode_t          header_mode;
	logic [1:0]            region_sel;
	logic [BSRAM_BITS-1:0] core_addr;
	logic [7:0]            core_d;
	logic                  core_we;
	logic                  core_rd;
	logic [7:0]            core_q;
	logic                  img_mounted;
	logic                  img_readonly;
	logic                  img_nonempty;
	logic                  bk_load;
	logic                  bk_save;
	logic                  autosave;
	logic                  osd_status;
	logic                  chk_hdr;
	logic                  sd_ack = 1'b0;
	logic [7:0]            sd_buff_addr = 8'd0;
	logic [15:0]           sd_buff_dout = 16'd0;
	logic                  sd_buff_wr = 1'b0;
	logic                  save_chk = 1'b0;
	logic [15:0]           sd_buff_din;
	logic [31:0]           sd_lba;
	logic                  sd_rd;
	logic                  sd_wr;
	logic                  cart_download;
	logic [7:0]            rom_type;
	mem_mask_t             rom_mask;
	mem_mask_t             ram_mask;
	logic                  pal;
	logic                  saving;
	logic                  bk_ena;
	logic                  pending;
	logic                  busy;
	logic                  led;

	logic [31:0] rng;
	logic [15:0] image [2**(BSRAM_BITS-1)];
	int          chk_errors;
	int          tb_errs = 0;
	int          host_errs = 0;
	int          host_sectors = 0;
	int          host_reqs = 0;

	cart_backup_top #(
		.BSRAM_BITS (BSRAM_BITS)
	) UUT (
		.clk_sys (clk_sys), .reset (reset), .download (download), .index (index),
		.addr (addr), .dout (dout), .wr (wr), .header_mode (header_mode),
		.region_sel (region_sel), .core_addr (core_addr), .core_d (core_d),
		.core_we (core_we), .core_q (core_q), .img_mounted (img_mounted),
		.img_readonly (img_readonly), .img_nonempty (img_nonempty), .bk_load (bk_load),
		.bk_save (bk_save), .autosave (autosave), .osd_status (osd_status),
		.sd_ack (sd_ack), .sd_buff_addr (sd_buff_addr), .sd_buff_dout (sd_buff_dout),
		.sd_buff_wr (sd_buff_wr), .sd_buff_din (sd_buff_din), .sd_lba (sd_lba),
		.sd_rd (sd_rd), .sd_wr (sd_wr), .cart_download (cart_download),
		.rom_type (rom_type), .rom_mask (rom_mask), .ram_mask (ram_mask), .pal (pal),
		.saving (saving), .bk_ena (bk_ena), .pending (pending), .busy (busy), .led (led)
	);

	cart_backup_checker #(
		.BSRAM_BITS (BSRAM_BITS)
	) u_checker (
		.clk_sys (clk_sys), .reset (reset), .download (download), .index (index),
		.addr (addr), .dout (dout), .wr (wr), .header_mode (header_mode),
		.region_sel (region_sel), .core_addr (core_addr), .core_d (core_d),
		.core_we (core_we), .core_rd (core_rd), .core_q (core_q), .sd_lba (sd_lba),
		.sd_buff_addr (sd_buff_addr), .sd_buff_dout (sd_buff_dout),
		.sd_buff_wr (sd_buff_wr), .sd_ack (sd_ack), .sd_buff_din (sd_buff_din),
		.save_chk (save_chk), .chk_hdr (chk_hdr), .rom_type (rom_type),
		.rom_mask (rom_mask), .ram_mask (ram_mask), .pal (pal),
		.cart_download (cart_download), .errors (chk_errors)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ====================
	// SD host model
	// ====================

	logic [1:0]  h_state = 2'd0;
	logic [3:0]  h_delay = 4'd0;
	logic        h_load = 1'b0;
	logic [8:0]  h_word = 9'd0;
	logic [31:0] h_last = 32'd0;
	logic [31:0] h_rng = 32'd74;

	always @(posedge clk_sys) begin
		case (h_state)
			2'd0: begin
				sd_buff_wr <= 1'b0;
				save_chk   <= 1'b0;
				if (!reset && (sd_rd || sd_wr)) begin
					host_reqs <= host_reqs + 1;
					if (sd_lba == 32'd0) begin
						host_sectors <= 1;
					end else if (sd_lba == h_last + 32'd1) begin
						host_sectors <= host_sectors + 1;
					end else begin
						$display("Error at %0t: host got sector %0d, expected %0d",
							$time, sd_lba, h_last + 32'd1);
						host_errs <= host_errs + 1;
					end
					h_last  <= sd_lba;
					h_load  <= sd_rd;
					h_rng   <= xorshift(h_rng);
					h_delay <= h_rng[3:0];
					h_state <= 2'd1;
				end
			end
			2'd1: begin
				if (h_delay == 4'd0) begin
					sd_ack  <= 1'b1;
					h_word  <= 9'd0;
					h_state <= 2'd2;
				end else begin
					h_delay <= h_delay - 4'd1;
				end
			end
			2'd2: begin
				sd_buff_addr <= h_word[7:0];
				if (h_load) begin
					sd_buff_dout <= image[{h_last[2:0], h_word[7:0]}];
					sd_buff_wr   <= 1'b1;
				end else begin
					save_chk <= 1'b1;
				end
				if (h_word == 9'd255) begin
					h_state <= 2'd3;
				end
				h_word <= h_word + 9'd1;
			end
			default: begin
				sd_buff_wr <= 1'b0;
				save_chk   <= 1'b0;
				sd_ack     <= 1'b0;
				h_state    <= 2'd0;
			end
		endcase
	end

	// ====================
	// Stimulus tasks
	// ====================

	task automatic wait_level(input int sel, input logic level, input int limit,
		input string what);
		int n;
		logic v;
		n = 0;
		v = ~level;
		while (v !== level && n < limit) begin
			@(posedge clk_sys);
			v = (sel == 0) ? busy : saving;
			n++;
		end
		if (v !== level) begin
			$display("Timed out after %0d cycles waiting for %s", limit, what);
			tb_errs++;
		end
	endtask

	task automatic check_value(input string what, input int got, input int want);
		if (got != want) begin
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
			tb_errs++;
		end
	endtask

	task automatic write_word(input logic [24:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		addr <= a;
		dout <= d;
		wr   <= 1'b1;
		@(posedge clk_sys);
		wr <= 1'b0;
	endtask

	task automatic send_cart(input header_mode_t m, input logic [15:0] first,
		input logic mounted, input logic ro);
		logic [24:0] ofs;
		case (m)
			HDR_LOROM:   ofs = 25'h00081D6;
			HDR_HIROM:   ofs = 25'h00101D6;
			default:     ofs = 25'h04101D6;
		endcase
		rng = xorshift(rng);
		@(posedge clk_sys);
		header_mode  <= m;
		region_sel   <= rng[1:0];
		index        <= {rng[3:2], 6'd0};
		img_mounted  <= mounted;
		img_readonly <= ro;
		img_nonempty <= mounted;
		download     <= 1'b1;
		wait_level(0, 1'b1, 8, "busy to rise after download start");
		write_word(25'd0, first);
		rng = xorshift(rng);
		write_word(25'd2, rng[15:0]);
		// Extra words land below the copier header
		for (int i = 0; i < 3; i++) begin
			rng = xorshift(rng);
			write_word({17'd0, rng[6:0], 1'b0} + 25'h100, rng[31:16]);
		end
		if (m != HDR_AUTO && m != HDR_NONE) begin
			rng = xorshift(rng);
			write_word(ofs, rng[15:0]);
			write_word(ofs + 25'd2, rng[31:16]);
		end
		wait_level(0, 1'b0, 5000, "fill to finish");
		@(posedge clk_sys);
		download <= 1'b0;
		repeat (2) @(posedge clk_sys);
		chk_hdr <= 1'b1;
		@(posedge clk_sys);
		chk_hdr <= 1'b0;
	endtask

	task automatic read_all;
		for (int a = 0; a < 2**BSRAM_BITS; a++) begin
			@(posedge clk_sys);
			core_addr <= a[BSRAM_BITS-1:0];
			core_rd   <= 1'b1;
		end
		@(posedge clk_sys);
		core_rd <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic core_write(input logic [BSRAM_BITS-1:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		core_addr <= a;
		core_d    <= d;
		core_we   <= 1'b1;
		@(posedge clk_sys);
		core_we <= 1'b0;
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		int reqs0;
		int seen;
		int total;
		download     = 1'b0;
		index        = 8'd0;
		addr         = 25'd0;
		dout         = 16'd0;
		wr           = 1'b0;
		header_mode  = HDR_AUTO;
		region_sel   = 2'b00;
		core_addr    = '0;
		core_d       = 8'd0;
		core_we      = 1'b0;
		core_rd      = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_nonempty = 1'b0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		autosave     = 1'b0;
		osd_status   = 1'b0;
		chk_hdr      = 1'b0;
		reset = 1'b1;
		rng = 32'd74;
		for (int i = 0; i < 2**(BSRAM_BITS-1); i++) begin
			rng = xorshift(rng);
			image[i] = rng[15:0];
		end
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		// Header decode in every mode, then the erased RAM
		for (int m = 0; m < 5; m++) begin
			rng = xorshift(rng);
			send_cart(header_mode_t'(m), rng[15:0], 1'b0, 1'b0);
		end
		rng = xorshift(rng);
		send_cart(HDR_AUTO, {rng[7:0], 8'h00}, 1'b0, 1'b0);
		read_all();

		// Automatic load from a writable image
		rng = xorshift(rng);
		send_cart(HDR_AUTO, {rng[7:0], 8'h2C}, 1'b1, 1'b0);
		wait_level(0, 1'b1, 20, "load to start");
		wait_level(0, 1'b0, 20000, "load to finish");
		check_value("loaded sectors", host_sectors, SECTORS);
		check_value("bk_ena after load", int'(bk_ena), 1);
		read_all();

		// Core writes then manual save
		for (int i = 0; i < 64; i++) begin
			rng = xorshift(rng);
			core_write(rng[BSRAM_BITS-1:0], rng[31:24]);
		end
		@(posedge clk_sys);
		bk_save <= 1'b1;
		repeat (2) @(posedge clk_sys);
		bk_save <= 1'b0;
		wait_level(1, 1'b1, 20, "save to start");
		wait_level(1, 1'b0, 20000, "save to finish");
		check_value("saved sectors", host_sectors, SECTORS);

		// Autosave when the menu opens
		rng = xorshift(rng);
		core_write(rng[BSRAM_BITS-1:0], rng[15:8]);
		@(posedge clk_sys);
		check_value("led after core write", int'(led), 1);
		osd_status <= 1'b1;
		autosave   <= 1'b1;
		wait_level(1, 1'b1, 20, "autosave to start");
		wait_level(1, 1'b0, 20000, "autosave to finish");
		check_value("pending after autosave", int'(pending), 0);
		osd_status <= 1'b0;
		autosave   <= 1'b0;

		// Read-only image gets no transfers
		rng = xorshift(rng);
		send_cart(HDR_AUTO, {rng[7:0], 8'h2C}, 1'b1, 1'b1);
		check_value("bk_ena with read-only image", int'(bk_ena), 0);
		reqs0 = host_reqs;
		bk_load <= 1'b1;
		repeat (2) @(posedge clk_sys);
		bk_load <= 1'b0;
		bk_save <= 1'b1;
		repeat (2) @(posedge clk_sys);
		bk_save <= 1'b0;
		seen = 0;
		for (int i = 0; i < 200; i++) begin
			@(posedge clk_sys);
			if (sd_rd || sd_wr) begin
				seen++;
			end
		end
		check_value("requests with read-only image", seen + host_reqs - reqs0, 0);

		repeat (4) @(posedge clk_sys);
		total = chk_errors + host_errs + tb_errs;
		$display("Errors: checker %0d, host %0d, sequence %0d", chk_errors, host_errs, tb_errs);
		if (total == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
design/loader_pkg.sv
design/backup_pkg.sv
design/cart_header_parser.sv
design/backup_ram.sv
design/backup_sequencer.sv
design/cart_backup_top.sv
tests/cart_backup_checker.sv
tests/cart_backup_tb.sv

// File: Makefile
# Verilator build and run for the cartridge backup testbench

VERILATOR ?= verilator
TOP       ?= cart_backup_tb
FILELIST  ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) design/*.sv tests/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
